//--- sparcPkg.sv
package sparcPkg;

	localparam int WORD_W = 32;
	localparam int MEM_WORDS = 256;
	localparam int MEM_ADDR_W = 8;
	localparam int MEM_LATENCY = 3;
	localparam int MEM_LAT_W = $clog2(MEM_LATENCY + 1);
	localparam int PSR_ICC_LSB = 20; // icc sits in PSR[23:20]

	// op field
	localparam logic [1:0] OP_FORMAT2 = 2'b00;
	localparam logic [1:0] OP_ARITH = 2'b10;
	localparam logic [1:0] OP_MEM = 2'b11;

	// op2 for format 2, taken from op3[5:3]
	localparam logic [2:0] OP2_BICC = 3'b010;
	localparam logic [2:0] OP2_SETHI = 3'b100;

	localparam logic [5:0] OP3_LD = 6'b000000;
	localparam logic [5:0] OP3_ST = 6'b000100;
	localparam logic [5:0] OP3_CC_MASK = 6'b010000; // Bit 4 selects the cc form

	// ALU ops follow op3 of the arithmetic group
	localparam logic [5:0] ALU_ADD = 6'b000000;
	localparam logic [5:0] ALU_AND = 6'b000001;
	localparam logic [5:0] ALU_OR = 6'b000010;
	localparam logic [5:0] ALU_XOR = 6'b000011;
	localparam logic [5:0] ALU_SUB = 6'b000100;
	localparam logic [5:0] ALU_PASSA = 6'b101110;
	localparam logic [5:0] ALU_PASSB = 6'b101111;

	// Bicc cond field
	localparam logic [3:0] COND_BN = 4'b0000;
	localparam logic [3:0] COND_BE = 4'b0001;
	localparam logic [3:0] COND_BL = 4'b0011;
	localparam logic [3:0] COND_BA = 4'b1000;
	localparam logic [3:0] COND_BNE = 4'b1001;
	localparam logic [3:0] COND_BGE = 4'b1011;

	typedef enum logic [1:0] {ALUA_REG, ALUA_PC, ALUA_NPC} aluASel_t;
	typedef enum logic [1:0] {ALUB_REG, ALUB_IMM, ALUB_FOUR} aluBSel_t;
	typedef enum logic [1:0] {EXT_SIMM13, EXT_SETHI, EXT_DISP22} extSel_t;
	typedef enum logic {PCIN_NPC, PCIN_ALU} pcInSel_t;
	typedef enum logic {MDR_MEM, MDR_REG} mdrSel_t;
	typedef enum logic {REGA_RS1, REGA_RD} regASel_t;

endpackage

//--- memLatencyTimer.sv
`timescale 1ns/10ps

module memLatencyTimer (
	input  logic Clk,
	input  logic RESET,
	input  logic Start,
	output logic Done
);
	import sparcPkg::*;

	logic [MEM_LAT_W-1:0] count;
	logic busy;

	always_ff @(posedge Clk)
	begin
		if (RESET)
		begin
			count <= '0;
			busy <= 1'b0;
		end
		else if (Start)
		begin
			count <= MEM_LAT_W'(MEM_LATENCY - 1);
			busy <= 1'b1;
		end
		else if (busy)
		begin
			if (count == '0)
				busy <= 1'b0; // Pulse delivered
			else
				count <= count - 1'b1;
		end
	end

	assign Done = busy && (count == '0);

endmodule

//--- sparcMemory.sv
`timescale 1ns/10ps

module sparcMemory (
	input  logic Clk,
	input  logic RESET,
	input  logic MemReq,
	input  logic MemWrite,
	input  logic [sparcPkg::WORD_W-1:0] Addr,
	input  logic [sparcPkg::WORD_W-1:0] WriteData,
	input  logic LoadEn,
	input  logic [sparcPkg::MEM_ADDR_W-1:0] LoadAddr,
	input  logic [sparcPkg::WORD_W-1:0] LoadData,
	output logic [sparcPkg::WORD_W-1:0] ReadData,
	output logic MFC
);
	import sparcPkg::*;

	logic [WORD_W-1:0] mem [MEM_WORDS];
	logic [MEM_ADDR_W-1:0] wordAddr;
	logic writeReq;
	logic done;

	memLatencyTimer timer (
		.Clk(Clk),
		.RESET(RESET),
		.Start(MemReq),
		.Done(done)
	);

	// Capture the request, byte address down to word index
	always_ff @(posedge Clk)
	begin
		if (RESET)
		begin
			wordAddr <= '0;
			writeReq <= 1'b0;
		end
		else if (MemReq)
		begin
			wordAddr <= Addr[MEM_ADDR_W+1:2];
			writeReq <= MemWrite;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (RESET)
		begin
			if (LoadEn)
				mem[LoadAddr] <= LoadData; // Program preload
		end
		else if (done && writeReq)
			mem[wordAddr] <= WriteData;
	end

	// Held until the next request moves wordAddr
	assign ReadData = mem[wordAddr];
	assign MFC = done;

endmodule

//--- sparcRegFile.sv
`timescale 1ns/10ps

module sparcRegFile (
	input  logic Clk,
	input  logic RESET,
	input  logic [4:0] ReadAddrA,
	input  logic [4:0] ReadAddrB,
	input  logic [4:0] WriteAddr,
	input  logic [sparcPkg::WORD_W-1:0] WriteData,
	input  logic WriteEn,
	output logic [sparcPkg::WORD_W-1:0] ReadDataA,
	output logic [sparcPkg::WORD_W-1:0] ReadDataB
);
	import sparcPkg::*;

	logic [WORD_W-1:0] regs [32];

	always_ff @(posedge Clk)
	begin
		if (RESET)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (WriteEn && WriteAddr != 5'd0)
			regs[WriteAddr] <= WriteData; // r0 never changes
	end

	// r0 reads as zero
	assign ReadDataA = (ReadAddrA == 5'd0) ? '0 : regs[ReadAddrA];
	assign ReadDataB = (ReadAddrB == 5'd0) ? '0 : regs[ReadAddrB];

endmodule

//--- sparcAlu.sv
`timescale 1ns/10ps

module sparcAlu (
	input  logic [sparcPkg::WORD_W-1:0] A,
	input  logic [sparcPkg::WORD_W-1:0] B,
	input  logic [5:0] AluOp,
	output logic [sparcPkg::WORD_W-1:0] Result,
	output logic [3:0] Flags
);
	import sparcPkg::*;

	logic [5:0] opBase;
	logic [WORD_W:0] wide;
	logic overflow;
	logic carry;

	assign opBase = AluOp & ~OP3_CC_MASK; // ADDcc acts as ADD here

	always_comb
	begin
		wide = '0;
		overflow = 1'b0;
		carry = 1'b0;
		case (opBase)
			ALU_ADD:
			begin
				wide = {1'b0, A} + {1'b0, B};
				overflow = (A[WORD_W-1] == B[WORD_W-1]) && (wide[WORD_W-1] != A[WORD_W-1]);
				carry = wide[WORD_W];
			end
			ALU_SUB:
			begin
				wide = {1'b0, A} - {1'b0, B};
				overflow = (A[WORD_W-1] != B[WORD_W-1]) && (wide[WORD_W-1] != A[WORD_W-1]);
				carry = wide[WORD_W]; // Borrow
			end
			ALU_AND: wide[WORD_W-1:0] = A & B;
			ALU_OR: wide[WORD_W-1:0] = A | B;
			ALU_XOR: wide[WORD_W-1:0] = A ^ B;
			ALU_PASSA: wide[WORD_W-1:0] = A;
			ALU_PASSB: wide[WORD_W-1:0] = B;
			default: wide = '0;
		endcase
	end

	assign Result = wide[WORD_W-1:0];
	// N Z V C
	assign Flags = {Result[WORD_W-1], (Result == '0), overflow, carry};

endmodule

//--- sparcDatapath.sv
`timescale 1ns/10ps

module sparcDatapath (
	input  logic Clk,
	input  logic RESET,
	input  logic PcClr,
	input  logic PsrClr,
	input  logic IrEn,
	input  logic PcEn,
	input  logic NpcEn,
	input  logic MarEn,
	input  logic MdrEn,
	input  logic PsrEn,
	input  logic RegWrite,
	input  sparcPkg::aluASel_t AluASel,
	input  sparcPkg::aluBSel_t AluBSel,
	input  sparcPkg::extSel_t ExtSel,
	input  sparcPkg::pcInSel_t PcInSel,
	input  sparcPkg::mdrSel_t MdrSel,
	input  sparcPkg::regASel_t RegASel,
	input  logic [5:0] AluOp,
	input  logic [sparcPkg::WORD_W-1:0] ReadData,
	output logic [1:0] Op,
	output logic [5:0] Op3,
	output logic [3:0] Cond,
	output logic Annul,
	output logic Imm,
	output logic BranchTaken,
	output logic [sparcPkg::WORD_W-1:0] MemAddr,
	output logic [sparcPkg::WORD_W-1:0] MemWriteData,
	output logic [4:0] RegWriteAddr,
	output logic [sparcPkg::WORD_W-1:0] RegWriteData,
	output logic [sparcPkg::WORD_W-1:0] Pc
);
	import sparcPkg::*;

	logic [WORD_W-1:0] ir, pc, npc, mar, mdr, psr;
	logic [WORD_W-1:0] regA, regB, extImm;
	logic [WORD_W-1:0] aluA, aluB, aluResult;
	logic [3:0] aluFlags;
	logic [3:0] icc;
	logic [4:0] regAddrA;

	assign Op = ir[31:30];
	assign Op3 = ir[24:19];
	assign Cond = ir[28:25];
	assign Annul = ir[29];
	assign Imm = ir[13];
	assign RegWriteAddr = ir[29:25];
	assign regAddrA = (RegASel == REGA_RD) ? ir[29:25] : ir[18:14];

	sparcRegFile regFile (
		.Clk(Clk),
		.RESET(RESET),
		.ReadAddrA(regAddrA),
		.ReadAddrB(ir[4:0]),
		.WriteAddr(ir[29:25]),
		.WriteData(RegWriteData),
		.WriteEn(RegWrite),
		.ReadDataA(regA),
		.ReadDataB(regB)
	);

	always_comb
	begin
		case (ExtSel)
			EXT_SIMM13: extImm = {{(WORD_W-13){ir[12]}}, ir[12:0]};
			EXT_SETHI: extImm = {ir[21:0], 10'b0};
			EXT_DISP22: extImm = {{(WORD_W-24){ir[21]}}, ir[21:0], 2'b00};
			default: extImm = '0;
		endcase
	end

	always_comb
	begin
		case (AluASel)
			ALUA_PC: aluA = pc;
			ALUA_NPC: aluA = npc;
			default: aluA = regA;
		endcase
		case (AluBSel)
			ALUB_IMM: aluB = extImm;
			ALUB_FOUR: aluB = WORD_W'(4);
			default: aluB = regB;
		endcase
	end

	sparcAlu alu (
		.A(aluA),
		.B(aluB),
		.AluOp(AluOp),
		.Result(aluResult),
		.Flags(aluFlags)
	);

	always_ff @(posedge Clk)
	begin
		if (RESET || PcClr)
		begin
			pc <= '0;
			npc <= WORD_W'(4);
		end
		else
		begin
			if (PcEn)
				pc <= (PcInSel == PCIN_ALU) ? aluResult : npc;
			if (NpcEn)
				npc <= aluResult;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (RESET || PsrClr)
			psr <= '0;
		else if (PsrEn)
			psr[PSR_ICC_LSB +: 4] <= aluFlags;
	end

	always_ff @(posedge Clk)
	begin
		if (IrEn)
			ir <= ReadData;
		if (MarEn)
			mar <= aluResult;
		if (MdrEn)
			mdr <= (MdrSel == MDR_REG) ? regA : ReadData;
	end

	// Bicc test on N Z V C
	assign icc = psr[PSR_ICC_LSB +: 4];
	always_comb
	begin
		case (Cond)
			COND_BA: BranchTaken = 1'b1;
			COND_BE: BranchTaken = icc[2];
			COND_BNE: BranchTaken = !icc[2];
			COND_BL: BranchTaken = icc[3] ^ icc[1];
			COND_BGE: BranchTaken = !(icc[3] ^ icc[1]);
			default: BranchTaken = 1'b0; // BN
		endcase
	end

	assign RegWriteData = (Op == OP_MEM) ? mdr : aluResult; // Loads write MDR
	assign MemAddr = mar;
	assign MemWriteData = mdr;
	assign Pc = pc;

endmodule

//--- sparcControl.sv
`timescale 1ns/10ps

module sparcControl (
	input  logic Clk,
	input  logic RESET,
	input  logic [1:0] Op,
	input  logic [5:0] Op3,
	input  logic [3:0] Cond,
	input  logic Annul,
	input  logic Imm,
	input  logic BranchTaken,
	input  logic MFC,
	output logic PcClr,
	output logic PsrClr,
	output logic IrEn,
	output logic PcEn,
	output logic NpcEn,
	output logic MarEn,
	output logic MdrEn,
	output logic PsrEn,
	output logic RegWrite,
	output sparcPkg::aluASel_t AluASel,
	output sparcPkg::aluBSel_t AluBSel,
	output sparcPkg::extSel_t ExtSel,
	output sparcPkg::pcInSel_t PcInSel,
	output sparcPkg::mdrSel_t MdrSel,
	output sparcPkg::regASel_t RegASel,
	output logic [5:0] AluOp,
	output logic MemReq,
	output logic MemWrite,
	output logic Halted
);
	import sparcPkg::*;

	typedef enum logic [4:0] {
		S_RESET,
		S_FETCH,
		S_FETCH_REQ,
		S_FETCH_WAIT,
		S_DECODE,
		S_SETHI,
		S_BRANCH,
		S_BR_SKIP,
		S_ARITH,
		S_LD_ADDR,
		S_LD_REQ,
		S_LD_WAIT,
		S_LD_WB,
		S_ST_ADDR,
		S_ST_DATA,
		S_ST_REQ,
		S_ST_WAIT,
		S_PC_FLOW,
		S_HALT
	} state_t;

	state_t state;
	state_t nextState;
	logic arithLegal;
	logic condLegal;
	logic annulTaken;

	// Only the kept arithmetic and logic op3 values
	assign arithLegal = ((Op3 & ~OP3_CC_MASK) inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR})
		|| (Op3 == ALU_XOR);
	assign condLegal = Cond inside {COND_BN, COND_BE, COND_BL, COND_BA, COND_BNE, COND_BGE};
	// BA,a skips the delay slot even though it is taken
	assign annulTaken = Annul && (Cond == COND_BA);

	always_ff @(posedge Clk)
	begin
		if (RESET)
			state <= S_RESET;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		PcClr = 1'b0;
		PsrClr = 1'b0;
		IrEn = 1'b0;
		PcEn = 1'b0;
		NpcEn = 1'b0;
		MarEn = 1'b0;
		MdrEn = 1'b0;
		PsrEn = 1'b0;
		RegWrite = 1'b0;
		AluASel = ALUA_REG;
		AluBSel = ALUB_REG;
		ExtSel = EXT_SIMM13;
		PcInSel = PCIN_NPC;
		MdrSel = MDR_MEM;
		RegASel = REGA_RS1;
		AluOp = ALU_ADD;
		MemReq = 1'b0;
		MemWrite = 1'b0;
		Halted = 1'b0;

		case (state)
			S_RESET:
			begin
				PcClr = 1'b1; // PC = 0, NPC = 4
				PsrClr = 1'b1;
				nextState = S_FETCH;
			end
			S_FETCH:
			begin
				AluASel = ALUA_PC;
				AluOp = ALU_PASSA;
				MarEn = 1'b1;
				nextState = S_FETCH_REQ;
			end
			S_FETCH_REQ:
			begin
				MemReq = 1'b1;
				nextState = S_FETCH_WAIT;
			end
			S_FETCH_WAIT:
			begin
				if (MFC)
				begin
					IrEn = 1'b1;
					nextState = S_DECODE;
				end
			end
			S_DECODE:
			begin
				nextState = S_HALT; // Anything not matched below
				case (Op)
					OP_FORMAT2:
					begin
						if (Op3[5:3] == OP2_SETHI)
							nextState = S_SETHI;
						else if (Op3[5:3] == OP2_BICC && condLegal)
							nextState = S_BRANCH;
					end
					OP_ARITH:
					begin
						if (arithLegal)
							nextState = S_ARITH;
					end
					OP_MEM:
					begin
						if (Op3 == OP3_LD)
							nextState = S_LD_ADDR;
						else if (Op3 == OP3_ST)
							nextState = S_ST_ADDR;
					end
					default: nextState = S_HALT; // CALL is not kept
				endcase
			end
			S_SETHI:
			begin
				ExtSel = EXT_SETHI;
				AluBSel = ALUB_IMM;
				AluOp = ALU_PASSB;
				RegWrite = 1'b1;
				nextState = S_PC_FLOW;
			end
			S_BRANCH:
			begin
				AluASel = ALUA_PC;
				AluBSel = ALUB_IMM;
				ExtSel = EXT_DISP22;
				if (BranchTaken && !annulTaken)
				begin
					// Delay slot runs, then the target
					PcEn = 1'b1;
					NpcEn = 1'b1;
					nextState = S_FETCH;
				end
				else if (BranchTaken)
				begin
					PcInSel = PCIN_ALU; // PC = target
					PcEn = 1'b1;
					nextState = S_BR_SKIP;
				end
				else if (Annul)
				begin
					// Not taken and annulled, PC = NPC + 4
					AluASel = ALUA_NPC;
					AluBSel = ALUB_FOUR;
					PcInSel = PCIN_ALU;
					PcEn = 1'b1;
					nextState = S_BR_SKIP;
				end
				else
				begin
					AluASel = ALUA_NPC;
					AluBSel = ALUB_FOUR;
					PcEn = 1'b1;
					NpcEn = 1'b1;
					nextState = S_FETCH;
				end
			end
			S_BR_SKIP:
			begin
				AluASel = ALUA_PC; // NPC = new PC + 4
				AluBSel = ALUB_FOUR;
				NpcEn = 1'b1;
				nextState = S_FETCH;
			end
			S_ARITH:
			begin
				AluBSel = Imm ? ALUB_IMM : ALUB_REG;
				AluOp = Op3;
				RegWrite = 1'b1;
				PsrEn = |(Op3 & OP3_CC_MASK);
				nextState = S_PC_FLOW;
			end
			S_LD_ADDR:
			begin
				AluBSel = Imm ? ALUB_IMM : ALUB_REG;
				MarEn = 1'b1;
				nextState = S_LD_REQ;
			end
			S_LD_REQ:
			begin
				MemReq = 1'b1;
				nextState = S_LD_WAIT;
			end
			S_LD_WAIT:
			begin
				if (MFC)
				begin
					MdrEn = 1'b1;
					nextState = S_LD_WB;
				end
			end
			S_LD_WB:
			begin
				RegWrite = 1'b1; // Datapath picks MDR for loads
				nextState = S_PC_FLOW;
			end
			S_ST_ADDR:
			begin
				AluBSel = Imm ? ALUB_IMM : ALUB_REG;
				MarEn = 1'b1;
				nextState = S_ST_DATA;
			end
			S_ST_DATA:
			begin
				RegASel = REGA_RD; // Store data is rd
				MdrSel = MDR_REG;
				MdrEn = 1'b1;
				nextState = S_ST_REQ;
			end
			S_ST_REQ:
			begin
				MemReq = 1'b1;
				MemWrite = 1'b1;
				nextState = S_ST_WAIT;
			end
			S_ST_WAIT:
			begin
				if (MFC)
					nextState = S_PC_FLOW;
			end
			S_PC_FLOW:
			begin
				// PC = NPC, NPC = NPC + 4
				AluASel = ALUA_NPC;
				AluBSel = ALUB_FOUR;
				PcEn = 1'b1;
				NpcEn = 1'b1;
				nextState = S_FETCH;
			end
			S_HALT:
			begin
				Halted = 1'b1;
			end
			default: nextState = S_RESET;
		endcase
	end

endmodule

//--- sparcCore.sv
`timescale 1ns/10ps

module sparcCore (
	input  logic Clk,
	input  logic RESET,
	input  logic LoadEn,
	input  logic [sparcPkg::MEM_ADDR_W-1:0] LoadAddr,
	input  logic [sparcPkg::WORD_W-1:0] LoadData,
	output logic RegWrite,
	output logic [4:0] RegWriteAddr,
	output logic [sparcPkg::WORD_W-1:0] RegWriteData,
	output logic [sparcPkg::WORD_W-1:0] Pc,
	output logic Halted
);
	import sparcPkg::*;

	logic pcClr, psrClr, irEn, pcEn, npcEn, marEn, mdrEn, psrEn;
	logic memReq, memWrite, mfc;
	logic annul, imm, branchTaken;
	logic [1:0] op;
	logic [5:0] op3, aluOp;
	logic [3:0] cond;
	aluASel_t aluASel;
	aluBSel_t aluBSel;
	extSel_t extSel;
	pcInSel_t pcInSel;
	mdrSel_t mdrSel;
	regASel_t regASel;
	logic [WORD_W-1:0] memAddr, memWriteData, memReadData;

	sparcControl control (
		.Clk(Clk), .RESET(RESET),
		.Op(op), .Op3(op3), .Cond(cond), .Annul(annul), .Imm(imm),
		.BranchTaken(branchTaken), .MFC(mfc),
		.PcClr(pcClr), .PsrClr(psrClr), .IrEn(irEn), .PcEn(pcEn), .NpcEn(npcEn),
		.MarEn(marEn), .MdrEn(mdrEn), .PsrEn(psrEn), .RegWrite(RegWrite),
		.AluASel(aluASel), .AluBSel(aluBSel), .ExtSel(extSel), .PcInSel(pcInSel),
		.MdrSel(mdrSel), .RegASel(regASel), .AluOp(aluOp),
		.MemReq(memReq), .MemWrite(memWrite), .Halted(Halted)
	);

	sparcDatapath datapath (
		.Clk(Clk), .RESET(RESET),
		.PcClr(pcClr), .PsrClr(psrClr), .IrEn(irEn), .PcEn(pcEn), .NpcEn(npcEn),
		.MarEn(marEn), .MdrEn(mdrEn), .PsrEn(psrEn), .RegWrite(RegWrite),
		.AluASel(aluASel), .AluBSel(aluBSel), .ExtSel(extSel), .PcInSel(pcInSel),
		.MdrSel(mdrSel), .RegASel(regASel), .AluOp(aluOp), .ReadData(memReadData),
		.Op(op), .Op3(op3), .Cond(cond), .Annul(annul), .Imm(imm),
		.BranchTaken(branchTaken), .MemAddr(memAddr), .MemWriteData(memWriteData),
		.RegWriteAddr(RegWriteAddr), .RegWriteData(RegWriteData), .Pc(Pc)
	);

	sparcMemory memory (
		.Clk(Clk), .RESET(RESET),
		.MemReq(memReq), .MemWrite(memWrite),
		.Addr(memAddr), .WriteData(memWriteData),
		.LoadEn(LoadEn), .LoadAddr(LoadAddr), .LoadData(LoadData),
		.ReadData(memReadData), .MFC(mfc)
	);

endmodule

//--- sparcCore_assert.sv
`timescale 1ns/10ps

module sparcCore_assert (
	input logic Clk,
	input logic RESET,
	input logic MemReq,
	input logic MFC,
	input logic PcEn,
	input logic IrEn,
	input logic Halted
);
	logic pending; // Request out, MFC not back yet
	int reqFails = 0;
	int enFails = 0;
	int haltFails = 0;

	always_ff @(posedge Clk)
	begin
		if (RESET)
			pending <= 1'b0;
		else if (MemReq)
			pending <= 1'b1;
		else if (MFC)
			pending <= 1'b0;
	end

	reqWhilePending: assert property (@(posedge Clk) disable iff (RESET) MemReq |-> !pending)
	else
	begin
		$error("MemReq raised while a request is pending");
		reqFails++;
	end

	// PC and IR hold while a request goes out
	enWithReq: assert property (@(posedge Clk) disable iff (RESET)
		MemReq |-> !(PcEn || IrEn))
	else
	begin
		$error("PcEn or IrEn high with MemReq");
		enFails++;
	end

	// S_HALT only leaves through reset
	haltSticky: assert property (@(posedge Clk) disable iff (RESET) Halted |=> Halted)
	else
	begin
		$error("Halted dropped without reset");
		haltFails++;
	end

endmodule

//--- sparcCore_tb.sv
`timescale 1ns/10ps

module sparcCore_tb;
	import sparcPkg::*;

	localparam int STEP_TIMEOUT = 200; // Cycles allowed per awaited event
	localparam int HALT_WINDOW = 100;

	logic Clk;
	logic RESET;
	logic LoadEn;
	logic [MEM_ADDR_W-1:0] LoadAddr;
	logic [WORD_W-1:0] LoadData;
	logic RegWrite;
	logic [4:0] RegWriteAddr;
	logic [WORD_W-1:0] RegWriteData;
	logic [WORD_W-1:0] Pc;
	logic Halted;

	// Program table, one row per memory word
	logic [31:0] progWord [$];
	logic progExp [$];
	logic [4:0] expAddr [$];
	logic [31:0] expData [$];
	string progName [$];

	int passCount;
	int failCount;
	int haltIndex;
	logic [31:0] constA;

	sparcCore DUT (
		.Clk(Clk),
		.RESET(RESET),
		.LoadEn(LoadEn),
		.LoadAddr(LoadAddr),
		.LoadData(LoadData),
		.RegWrite(RegWrite),
		.RegWriteAddr(RegWriteAddr),
		.RegWriteData(RegWriteData),
		.Pc(Pc),
		.Halted(Halted)
	);

	bind sparcControl sparcCore_assert ctrlAssert (
		.Clk(Clk),
		.RESET(RESET),
		.MemReq(MemReq),
		.MFC(MFC),
		.PcEn(PcEn),
		.IrEn(IrEn),
		.Halted(Halted)
	);

	initial
	begin
		Clk = 1'b0;
		forever #4 Clk = ~Clk;
	end

	// Format 3 with simm13 operand
	function automatic logic [31:0] encImm(input logic [1:0] op, input logic [5:0] op3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [12:0] simm);
		return {op, rd, op3, rs1, 1'b1, simm};
	endfunction

	function automatic logic [31:0] encReg(input logic [1:0] op, input logic [5:0] op3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {op, rd, op3, rs1, 1'b0, 8'b0, rs2};
	endfunction

	function automatic logic [31:0] encSethi(input logic [4:0] rd, input logic [21:0] imm22);
		return {OP_FORMAT2, rd, OP2_SETHI, imm22};
	endfunction

	function automatic logic [31:0] encBranch(input logic a, input logic [3:0] cond,
		input logic [21:0] disp22);
		return {OP_FORMAT2, a, cond, OP2_BICC, disp22};
	endfunction

	function automatic logic [31:0] signExt13(input logic [12:0] v);
		return {{19{v[12]}}, v};
	endfunction

	task automatic addRow(input logic [31:0] word, input logic hasExp, input logic [4:0] rd,
		input logic [31:0] data, input string name);
		progWord.push_back(word);
		progExp.push_back(hasExp);
		expAddr.push_back(rd);
		expData.push_back(data);
		progName.push_back(name);
	endtask

	// Instruction that must never reach the trace
	task automatic addSkip(input string name);
		addRow(encImm(OP_ARITH, ALU_ADD, 5'd26, 5'd0, 13'hBAD), 1'b0, 5'd0, 32'h0, name);
	endtask

	task automatic buildProgram();
		logic [31:0] rndA;
		logic [31:0] rndB;
		logic [5:0] cc;
		int k;
		cc = OP3_CC_MASK;
		constA = 32'hC0DE_5A5A;
		// SETHI then OR builds constA in r1
		addRow(encSethi(5'd1, constA[31:10]), 1'b1, 5'd1, {constA[31:10], 10'b0}, "sethi r1");
		addRow(encImm(OP_ARITH, ALU_OR, 5'd1, 5'd1, {3'b000, constA[9:0]}), 1'b1, 5'd1,
			constA, "or r1 low");
		addRow(encImm(OP_ARITH, ALU_ADD, 5'd2, 5'd0, 13'd100), 1'b1, 5'd2, 32'd100, "add imm");
		addRow(encImm(OP_ARITH, ALU_SUB, 5'd3, 5'd2, 13'd30), 1'b1, 5'd3, 32'd70, "sub imm");
		addRow(encReg(OP_ARITH, ALU_ADD, 5'd4, 5'd2, 5'd3), 1'b1, 5'd4, 32'd170, "add reg");
		addRow(encReg(OP_ARITH, ALU_SUB, 5'd5, 5'd3, 5'd2), 1'b1, 5'd5, 32'd70 - 32'd100,
			"sub reg");
		addRow(encImm(OP_ARITH, ALU_AND, 5'd6, 5'd1, 13'h0FF), 1'b1, 5'd6, constA & 32'hFF,
			"and imm");
		addRow(encReg(OP_ARITH, ALU_XOR, 5'd7, 5'd1, 5'd5), 1'b1, 5'd7,
			constA ^ (32'd70 - 32'd100), "xor reg");
		addRow(encImm(OP_ARITH, ALU_ADD, 5'd8, 5'd0, 13'h1FFB), 1'b1, 5'd8, 32'hFFFF_FFFB,
			"add neg imm"); // -5 sign extended
		addRow(encReg(OP_ARITH, ALU_ADD | cc, 5'd12, 5'd2, 5'd3), 1'b1, 5'd12, 32'd170, "addcc");
		addRow(encImm(OP_ARITH, ALU_OR | cc, 5'd13, 5'd4, 13'h300), 1'b1, 5'd13,
			32'd170 | 32'h300, "orcc");
		addRow(encReg(OP_ARITH, ALU_AND | cc, 5'd14, 5'd1, 5'd6), 1'b1, 5'd14, constA & 32'hFF,
			"andcc");
		addRow(encImm(OP_ARITH, ALU_OR, 5'd0, 5'd2, 13'd7), 1'b1, 5'd0, 32'd103, "write r0");
		addRow(encImm(OP_ARITH, ALU_ADD, 5'd9, 5'd0, 13'd1), 1'b1, 5'd9, 32'd1, "read r0");
		for (k = 0; k < 3; k++)
		begin
			rndA = $urandom;
			rndB = $urandom;
			addRow(encImm(OP_ARITH, ALU_ADD, 5'd10, 5'd0, rndA[12:0]), 1'b1, 5'd10,
				signExt13(rndA[12:0]), "rand load");
			addRow(encImm(OP_ARITH, ALU_ADD, 5'd11, 5'd10, rndB[12:0]), 1'b1, 5'd11,
				signExt13(rndA[12:0]) + signExt13(rndB[12:0]), "rand sum");
		end
		// Store and load back through byte address 0x200
		addRow(encImm(OP_ARITH, ALU_ADD, 5'd20, 5'd0, 13'h200), 1'b1, 5'd20, 32'h200, "base");
		addRow(encImm(OP_MEM, OP3_ST, 5'd1, 5'd20, 13'd4), 1'b0, 5'd0, 32'h0, "st r1");
		addRow(encImm(OP_MEM, OP3_ST, 5'd7, 5'd20, 13'd8), 1'b0, 5'd0, 32'h0, "st r7");
		addRow(encImm(OP_MEM, OP3_LD, 5'd21, 5'd20, 13'd4), 1'b1, 5'd21, constA, "ld imm");
		addRow(encImm(OP_ARITH, ALU_ADD, 5'd23, 5'd0, 13'd8), 1'b1, 5'd23, 32'd8, "offset");
		addRow(encReg(OP_MEM, OP3_LD, 5'd22, 5'd20, 5'd23), 1'b1, 5'd22,
			constA ^ (32'd70 - 32'd100), "ld reg");
		// Z set, then BE / BNE with and without annul
		addRow(encImm(OP_ARITH, ALU_SUB | cc, 5'd24, 5'd2, 13'd100), 1'b1, 5'd24, 32'd0, "subcc z");
		addRow(encBranch(1'b0, COND_BE, 22'd3), 1'b0, 5'd0, 32'h0, "be taken");
		addRow(encImm(OP_ARITH, ALU_ADD, 5'd25, 5'd0, 13'd1), 1'b1, 5'd25, 32'd1, "be slot");
		addSkip("be target skip");
		addRow(encBranch(1'b1, COND_BNE, 22'd3), 1'b0, 5'd0, 32'h0, "bne,a not taken");
		addSkip("bne,a slot");
		addRow(encBranch(1'b0, COND_BNE, 22'd2), 1'b0, 5'd0, 32'h0, "bne not taken");
		addRow(encImm(OP_ARITH, ALU_ADD, 5'd27, 5'd0, 13'd2), 1'b1, 5'd27, 32'd2, "bne slot");
		addRow(encBranch(1'b1, COND_BE, 22'd3), 1'b0, 5'd0, 32'h0, "be,a taken");
		addRow(encImm(OP_ARITH, ALU_ADD, 5'd28, 5'd0, 13'd3), 1'b1, 5'd28, 32'd3, "be,a slot");
		addSkip("be,a target skip");
		addRow(encReg(OP_ARITH, ALU_SUB | cc, 5'd24, 5'd3, 5'd2), 1'b1, 5'd24,
			32'd70 - 32'd100, "subcc neg");
		addRow(encBranch(1'b1, COND_BE, 22'd3), 1'b0, 5'd0, 32'h0, "be,a not taken");
		addSkip("be,a slot");
		addRow(encBranch(1'b1, COND_BNE, 22'd3), 1'b0, 5'd0, 32'h0, "bne,a taken");
		addRow(encImm(OP_ARITH, ALU_ADD, 5'd29, 5'd0, 13'd4), 1'b1, 5'd29, 32'd4, "bne,a slot");
		addSkip("bne,a target skip");
		addRow(encBranch(1'b0, COND_BL, 22'd3), 1'b0, 5'd0, 32'h0, "bl taken");
		addRow(encImm(OP_ARITH, ALU_ADD, 5'd30, 5'd0, 13'd5), 1'b1, 5'd30, 32'd5, "bl slot");
		addSkip("bl target skip");
		// BA,a and BN,a skip the slot, plain BN runs it
		addRow(encBranch(1'b1, COND_BA, 22'd3), 1'b0, 5'd0, 32'h0, "ba,a");
		addSkip("ba,a slot");
		addSkip("ba,a gap");
		addRow(encBranch(1'b1, COND_BN, 22'd4), 1'b0, 5'd0, 32'h0, "bn,a");
		addSkip("bn,a slot");
		addRow(encBranch(1'b0, COND_BN, 22'd4), 1'b0, 5'd0, 32'h0, "bn");
		addRow(encImm(OP_ARITH, ALU_ADD, 5'd31, 5'd0, 13'd6), 1'b1, 5'd31, 32'd6, "bn slot");
		addRow(encImm(OP_ARITH, ALU_ADD, 5'd31, 5'd31, 13'd1), 1'b1, 5'd31, 32'd7, "bn next");
		haltIndex = progWord.size();
		addRow(encImm(OP_ARITH, 6'b100101, 5'd1, 5'd1, 13'd1), 1'b0, 5'd0, 32'h0, "illegal sll");
		addSkip("after halt");
		addSkip("after halt");
	endtask

	task automatic checkValue(input string sigName, input logic [31:0] got,
		input logic [31:0] exp, output logic match);
		match = (got === exp);
		if (!match)
			$display("[FAIL] t=%0t %s got=%h expected=%h", $time, sigName, got, exp);
	endtask

	task automatic waitRegWrite(output logic seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < STEP_TIMEOUT)
		begin
			@(negedge Clk); // Outputs settled here
			seen = RegWrite;
			cycles++;
		end
	endtask

	task automatic waitHalted(output logic seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < STEP_TIMEOUT)
		begin
			@(negedge Clk);
			seen = Halted;
			cycles++;
		end
	endtask

	initial
	begin
		int idx;
		int extra;
		int assertFails;
		logic seen;
		logic aborted;
		logic okAddr;
		logic okData;
		logic okPc;
		logic dropped;

		RESET = 1'b1;
		LoadEn = 1'b0;
		LoadAddr = '0;
		LoadData = '0;
		passCount = 0;
		failCount = 0;
		aborted = 1'b0;
		dropped = 1'b0;
		extra = 0;
		void'($urandom(81737));
		buildProgram();

		// Reset covers the preload, then 3 more cycles
		for (idx = 0; idx < progWord.size(); idx++)
		begin
			@(posedge Clk);
			LoadEn <= 1'b1;
			LoadAddr <= MEM_ADDR_W'(idx);
			LoadData <= progWord[idx];
		end
		@(posedge Clk);
		LoadEn <= 1'b0;
		repeat (3) @(posedge Clk);
		RESET <= 1'b0;

		// Trace must follow the table rows that expect a write, in order
		for (idx = 0; idx < progWord.size() && !aborted; idx++)
		begin
			if (progExp[idx])
			begin
				waitRegWrite(seen);
				if (!seen)
				begin
					$display("Timeout: no register write seen for test %s", progName[idx]);
					failCount++;
					aborted = 1'b1;
				end
				else
				begin
					checkValue("RegWriteAddr", {27'b0, RegWriteAddr}, {27'b0, expAddr[idx]},
						okAddr);
					checkValue("RegWriteData", RegWriteData, expData[idx], okData);
					if (okAddr && okData)
						passCount++;
					else
						failCount++;
					$display("test %s: %s", progName[idx], (okAddr && okData) ? "ok" : "error");
				end
			end
		end

		if (!aborted)
		begin
			waitHalted(seen);
			if (!seen)
			begin
				$display("Timeout: core never raised Halted on the illegal instruction");
				failCount++;
			end
			else
			begin
				checkValue("Pc", Pc, 32'(haltIndex * 4), okPc);
				repeat (HALT_WINDOW)
				begin
					@(negedge Clk);
					if (RegWrite)
						extra++;
					if (!Halted)
						dropped = 1'b1;
				end
				if (extra != 0)
					$display("Core wrote %0d registers after halting", extra);
				if (dropped)
					$display("Halted dropped before reset");
				if (okPc && extra == 0 && !dropped)
					passCount++;
				else
					failCount++;
				$display("test halt: %s", (okPc && extra == 0 && !dropped) ? "ok" : "error");
			end
		end

		assertFails = DUT.control.ctrlAssert.reqFails + DUT.control.ctrlAssert.enFails
			+ DUT.control.ctrlAssert.haltFails;
		if (assertFails != 0)
		begin
			$display("Control assertions fired %0d times", assertFails);
			failCount++;
		end

		$display("Tests: %0d passed, %0d failed", passCount, failCount);
		if (failCount == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- files.f
sparcPkg.sv
memLatencyTimer.sv
sparcMemory.sv
sparcRegFile.sv
sparcAlu.sv
sparcDatapath.sv
sparcControl.sv
sparcCore.sv
sparcCore_assert.sv
sparcCore_tb.sv

//--- Makefile
TOP = sparcCore_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --assert -f files.f --top-module $(TOP) -o simv
	./obj_dir/simv +verilator+error+limit+100 | tee /dev/stderr | grep -qx "Simulation PASSED"

lint:
	verilator --lint-only -Wall --timing --assert -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir
